//--- rv32iDatapath.f
hw/rvIsaPkg.sv
hw/rvCtrlPkg.sv
hw/decodeIf.sv
hw/ctrlIf.sv
hw/instrDecoder.sv
hw/controlUnit.sv
hw/alu.sv
hw/registerFile.sv
hw/memoryHandler.sv
hw/rv32iDatapath.sv
verification/rv32iDatapathTb.sv

//--- Bender.yml
package:
  name: rv32iDatapath

sources:
  - files:
      - hw/rvIsaPkg.sv
      - hw/rvCtrlPkg.sv
      - hw/decodeIf.sv
      - hw/ctrlIf.sv
      - hw/instrDecoder.sv
      - hw/controlUnit.sv
      - hw/alu.sv
      - hw/registerFile.sv
      - hw/memoryHandler.sv
      - hw/rv32iDatapath.sv
  - target: test
    files:
      - verification/rv32iDatapathTb.sv

//--- verification/rv32iDatapathTb.sv
`default_nettype none

module rv32iDatapathTb;
    import rvIsaPkg::*;
    import rvCtrlPkg::*;

    localparam int   clkPeriod = 10;
    localparam int   edgeLimit = 4 * clkPeriod; // longest wait for one falling edge
    localparam wordT nop       = 32'h0000_0013; // addi x0,x0,0

    logic   clk, arstN, zeroFlag, branchTaken, errFlag, memRead, memWrite;
    wordT   instr, memRData, aluResult, memAddr, memWData;
    byteEnT memByteEn;

    wordT   shadowRegs [32]; // expected register contents
    wordT   memModel [64];   // 256 bytes, word index memAddr[7:2]
    wordT   opA, opB, immI, immS, expResult, wbVal, expWData;
    byteEnT expBe;
    logic   checkAlu, expTaken, expErr, expRead, expWrite, expRegWr;

    funct3T branchKinds [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    funct3T loadKinds [5]   = '{3'b000, 3'b100, 3'b001, 3'b101, 3'b010}; // lb lbu lh lhu lw
    opcodeT badOpcodes [3]  = '{7'b1101111, 7'b1100111, 7'b0010111};    // jal, jalr, auipc

    rv32iDatapath dut (.*);

    assign memRData = memModel[memAddr[7:2]]; // memory answers in the same cycle

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    function automatic wordT rType(input funct7T f7, input regAddrT rs2, rs1,
                                   input funct3T f3, input regAddrT rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic wordT iType(input logic [11:0] imm, input regAddrT rs1,
                                   input funct3T f3, input regAddrT rd, input opcodeT opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic wordT sType(input logic [11:0] imm, input regAddrT rs2, rs1,
                                   input funct3T f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE}; // offset split around rs fields
    endfunction

    function automatic wordT bType(input logic [12:0] off, input regAddrT rs2, rs1,
                                   input funct3T f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic wordT aluCalc(input funct3T f3, input logic alt, input logic isOp,
                                     input wordT a, input wordT b);
        case (f3)
            3'b000:  return (isOp && alt) ? a - b : a + b; // sub only for reg-reg
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? wordT'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branchCond(input funct3T f3, input wordT a, input wordT b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0; // kinds 2 and 3 do not exist
        endcase
    endfunction

    function automatic wordT loadExtend(input funct3T f3, input wordT w, input logic [1:0] lane);
        wordT s;
        s = w >> {lane, 3'b000}; // addressed lane down to bit 0
        case (f3)
            3'b000:  return {{24{s[7]}}, s[7:0]};
            3'b100:  return {24'b0, s[7:0]};
            3'b001:  return {{16{s[15]}}, s[15:0]};
            3'b101:  return {16'b0, s[15:0]};
            default: return w;
        endcase
    endfunction

    function automatic wordT laneMask(input byteEnT be);
        wordT m;
        for (int i = 0; i < 4; i++) begin
            m[8 * i +: 8] = {8{be[i]}};
        end
        return m;
    endfunction

    // expected outputs for the instruction on the bus
    always_comb begin
        opA       = shadowRegs[instr[19:15]];
        opB       = shadowRegs[instr[24:20]];
        immI      = {{20{instr[31]}}, instr[31:20]};
        immS      = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        expResult = '0;
        wbVal     = '0;
        expWData  = '0;
        expBe     = '0;
        {checkAlu, expTaken, expErr, expRead, expWrite, expRegWr} = '0;
        case (instr[6:0])
            OPC_OP, OPC_OPIMM: begin
                expResult = aluCalc(instr[14:12], instr[30], instr[6:0] == OPC_OP, opA,
                                    instr[6:0] == OPC_OP ? opB : immI);
                wbVal     = expResult;
                checkAlu  = 1'b1;
                expRegWr  = 1'b1;
            end
            OPC_LOAD: begin
                expResult = opA + immI;
                wbVal     = loadExtend(instr[14:12], memModel[expResult[7:2]], expResult[1:0]);
                checkAlu  = 1'b1;
                expRead   = 1'b1;
                expRegWr  = 1'b1;
            end
            OPC_STORE: begin
                expResult = opA + immS;
                expBe     = instr[13:12] == 2'd0 ? byteEnT'(4'b0001 << expResult[1:0]) :
                            instr[13:12] == 2'd1 ? byteEnT'(4'b0011 << expResult[1:0]) : 4'hf;
                expWData  = opB << {expResult[1:0], 3'b000}; // data sits in its own lanes
                checkAlu  = 1'b1;
                expWrite  = 1'b1;
            end
            OPC_BRANCH: begin
                expResult = opA - opB;
                expTaken  = branchCond(instr[14:12], opA, opB);
                expErr    = instr[14:13] == 2'b01;
                checkAlu  = 1'b1;
            end
            OPC_LUI: begin
                wbVal    = {instr[31:12], 12'b0};
                expRegWr = 1'b1;
            end
            default: expErr = 1'b1;
        endcase
    end

    always @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                shadowRegs[i] <= '0;
            end
        end else if (expRegWr && instr[11:7] != 5'd0) begin // x0 never written
            shadowRegs[instr[11:7]] <= wbVal;
        end
    end

    always @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (arstN && memWrite && memByteEn[i]) begin
                memModel[memAddr[7:2]][8 * i +: 8] <= memWData[8 * i +: 8];
            end
        end
    end

    task automatic reportFail(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1, "stopped at first failure");
    endtask

    aluCheck: assert property (@(posedge clk) disable iff (!arstN)
        checkAlu |-> aluResult == expResult && zeroFlag == (expResult == '0))
        else reportFail($sformatf("[ERROR] %0t: aluResult %h zeroFlag %b, expected %h, instr %h",
            $time, $sampled(aluResult), $sampled(zeroFlag), $sampled(expResult), $sampled(instr)));

    ctrlCheck: assert property (@(posedge clk) disable iff (!arstN)
        branchTaken == expTaken && errFlag == expErr && memRead == expRead && memWrite == expWrite)
        else reportFail($sformatf("[ERROR] %0t: taken/err/rd/wr %b%b%b%b, expected %b%b%b%b",
            $time, $sampled(branchTaken), $sampled(errFlag), $sampled(memRead),
            $sampled(memWrite), $sampled(expTaken), $sampled(expErr), $sampled(expRead),
            $sampled(expWrite)));

    storeCheck: assert property (@(posedge clk) disable iff (!arstN)
        expWrite |-> memAddr == {expResult[31:2], 2'b00} && memByteEn == expBe &&
        (memWData & laneMask(expBe)) == (expWData & laneMask(expBe)))
        else reportFail($sformatf("[ERROR] %0t: store addr %h be %b data %h, expected %h %b %h",
            $time, $sampled(memAddr), $sampled(memByteEn), $sampled(memWData),
            $sampled(expResult), $sampled(expBe), $sampled(expWData)));

    idleLanesCheck: assert property (@(posedge clk) disable iff (!arstN)
        !expWrite |-> memByteEn == '0)
        else reportFail($sformatf("[ERROR] %0t: memByteEn %b without a store",
            $time, $sampled(memByteEn)));

    task automatic nextFall();
        logic fell;
        fell = 1'b0;
        fork
            begin
                @(negedge clk);
                fell = 1'b1;
            end
            #(edgeLimit);
        join_any
        disable fork;
        if (!fell) begin
            reportFail("Timeout: no falling clock edge, the clock has stopped");
        end
    endtask

    task automatic issue(input wordT w);
        nextFall();
        instr <= w; // held until the next falling edge
    endtask

    task automatic sweepRegs();
        for (int r = 0; r < 32; r++) begin
            issue(iType(12'd0, regAddrT'(r), 3'b000, 5'd0, OPC_OPIMM)); // xr shows on aluResult
        end
    endtask

    initial begin
        int          seedState;
        funct3T      f3;
        regAddrT     rs;
        logic        alt;
        logic [11:0] off;
        seedState = $urandom(60);
        instr     = nop;
        arstN     = 1'b0;
        for (int i = 0; i < 64; i++) begin
            memModel[i] = wordT'(4 * i) * 32'h9E37_79B9 ^ 32'h5A5A_0F0F; // unique per address
        end
        for (int i = 0; i < 8; i++) begin
            nextFall();
        end
        arstN <= 1'b1;
        sweepRegs(); // reset leaves all zero
        for (int r = 1; r < 32; r++) begin
            issue({20'($urandom), regAddrT'(r), OPC_LUI});
            issue(iType(12'($urandom), regAddrT'(r), 3'b000, regAddrT'(r), OPC_OPIMM));
        end
        for (int n = 0; n < 300; n++) begin
            f3  = funct3T'($urandom_range(7, 0));
            alt = (f3 == 3'b000 || f3 == 3'b101) && $urandom_range(1, 0); // sub, sra, srai
            if ($urandom_range(1, 0) == 0) begin
                issue(rType({1'b0, alt, 5'b0}, 5'($urandom), 5'($urandom), f3, 5'($urandom)));
            end else if (f3 == 3'b001 || f3 == 3'b101) begin
                issue(iType({1'b0, alt, 5'b0, 5'($urandom)}, 5'($urandom), f3, 5'($urandom),
                            OPC_OPIMM));
            end else begin
                issue(iType(12'($urandom), 5'($urandom), f3, 5'($urandom), OPC_OPIMM));
            end
        end
        sweepRegs();
        for (int n = 0; n < 60; n++) begin
            rs = 5'($urandom);
            issue(bType(13'($urandom) & ~13'd1, $urandom_range(3, 0) == 0 ? rs : 5'($urandom),
                        rs, branchKinds[n % 6])); // some equal pairs
        end
        sweepRegs(); // branches write nothing
        issue(iType(12'h040, 5'd0, 3'b000, 5'd10, OPC_OPIMM)); // x10 is the memory base
        for (int n = 0; n < 45; n++) begin
            f3  = funct3T'(n % 3);
            off = 12'($urandom_range(127, 0)) & ~12'((1 << f3) - 1); // aligned to size
            issue(sType(off, 5'($urandom), 5'd10, f3));
        end
        for (int n = 0; n < 45; n++) begin
            f3  = loadKinds[n % 5];
            off = 12'($urandom_range(127, 0)) & ~12'((1 << f3[1:0]) - 1);
            rs  = 5'($urandom_range(31, 11)); // base in x10 kept
            issue(iType(off, 5'd10, f3, rs, OPC_LOAD));
            issue(iType(12'd0, rs, 3'b000, 5'd0, OPC_OPIMM)); // loaded value on aluResult
        end
        sweepRegs();
        for (int n = 0; n < 12; n++) begin
            issue({25'($urandom), badOpcodes[n % 3]});
        end
        sweepRegs(); // nothing changed by illegal ones
        issue(nop);
        nextFall();
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/rv32iDatapath.sv
`default_nettype none

module rv32iDatapath (
    input  logic              clk,
    input  logic              arstN,       // async, active low
    input  rvIsaPkg::wordT    instr,       // current instruction
    input  rvIsaPkg::wordT    memRData,    // combinational read data
    output rvIsaPkg::wordT    aluResult,
    output logic              zeroFlag,
    output logic              branchTaken, // condition only, no pc
    output logic              errFlag,     // unsupported instruction
    output rvIsaPkg::wordT    memAddr,
    output rvIsaPkg::wordT    memWData,
    output rvCtrlPkg::byteEnT memByteEn,
    output logic              memRead,
    output logic              memWrite
);
    import rvIsaPkg::*;

    decodeIf dec ();  // decoder fields
    ctrlIf   ctrl (); // control levels

    wordT regA;     // rs1 value
    wordT regB;     // rs2 value, store data
    wordT loadData; // extended load for write-back

    instrDecoder decoder (
        .instr (instr),
        .dec   (dec)
    );

    controlUnit control (
        .dec  (dec),
        .ctrl (ctrl)
    );

    alu aluUnit (
        .dec         (dec),
        .ctrl        (ctrl),
        .regA        (regA),
        .regB        (regB),
        .result      (aluResult),   // also the memory address
        .zeroFlag    (zeroFlag),
        .branchTaken (branchTaken)
    );

    registerFile regs (
        .clk       (clk),
        .arstN     (arstN),
        .dec       (dec),
        .ctrl      (ctrl),
        .aluResult (aluResult),
        .memData   (loadData),
        .regA      (regA),
        .regB      (regB)
    );

    memoryHandler memHandler (
        .dec       (dec),
        .ctrl      (ctrl),
        .addr      (aluResult),
        .storeData (regB),
        .memRData  (memRData),
        .loadData  (loadData),
        .memAddr   (memAddr),
        .memWData  (memWData),
        .memByteEn (memByteEn),
        .memRead   (memRead),
        .memWrite  (memWrite)
    );

    assign errFlag = ctrl.illegal;

endmodule

`default_nettype wire

//--- hw/memoryHandler.sv
`default_nettype none

module memoryHandler (
    decodeIf.dst                dec,       // funct3 = size
    ctrlIf.dst                  ctrl,      // memRead, memWrite
    input  rvIsaPkg::wordT      addr,      // byte address from alu
    input  rvIsaPkg::wordT      storeData, // rs2 value
    input  rvIsaPkg::wordT      memRData,  // word from memory
    output rvIsaPkg::wordT      loadData,  // extended, to reg file
    output rvIsaPkg::wordT      memAddr,
    output rvIsaPkg::wordT      memWData,
    output rvCtrlPkg::byteEnT   memByteEn,
    output logic                memRead,
    output logic                memWrite
);
    import rvIsaPkg::*;
    import rvCtrlPkg::*;

    logic [1:0]  lane;       // byte offset in word
    funct3T      size;       // funct3 with unsigned bit stripped
    logic        isUnsigned;
    logic [7:0]  rByte;
    logic [15:0] rHalf;

    assign lane       = addr[1:0];
    assign size       = {1'b0, dec.funct3[1:0]};
    assign isUnsigned = dec.funct3[SZ_UNSIGNED_BIT];
    assign memAddr    = {addr[31:2], 2'b00}; // word aligned
    assign memRead    = ctrl.memRead;
    assign memWrite   = ctrl.memWrite;

    // store side, data copied to every lane
    always_comb begin
        case (size)
            SZ_BYTE: begin
                memWData  = {4{storeData[7:0]}};
                memByteEn = BE_BYTE << lane;
            end
            SZ_HALF: begin
                memWData  = {2{storeData[15:0]}};
                memByteEn = BE_HALF << {lane[1], 1'b0}; // lower or upper half
            end
            default: begin
                memWData  = storeData;
                memByteEn = BE_WORD;
            end
        endcase
        if (!ctrl.memWrite) begin
            memByteEn = BE_NONE; // no stray lane writes
        end
    end

    // load side
    assign rByte = memRData[{lane, 3'b000} +: 8];
    assign rHalf = lane[1] ? memRData[31:16] : memRData[15:0];

    always_comb begin
        case (size)
            SZ_BYTE: loadData = isUnsigned ? {24'b0, rByte} : {{24{rByte[7]}}, rByte};
            SZ_HALF: loadData = isUnsigned ? {16'b0, rHalf} : {{16{rHalf[15]}}, rHalf};
            default: loadData = memRData; // lw
        endcase
    end

    // alignment, the alu address must suit the access size
    always_comb begin
        accessAligned: assert final (!(ctrl.memRead || ctrl.memWrite) ||
                                     (size == SZ_HALF ? !addr[0] :
                                      size == SZ_WORD ? (addr[1:0] == 2'b00) : 1'b1))
            else $error("misaligned access, addr %h size %0d", addr, size);
    end

endmodule

`default_nettype wire

//--- hw/registerFile.sv
`default_nettype none

module registerFile (
    input  logic           clk,
    input  logic           arstN,     // clears all entries
    decodeIf.dst           dec,       // rs1, rs2, rd, imm
    ctrlIf.dst             ctrl,      // wbSel, regWrite
    input  rvIsaPkg::wordT aluResult,
    input  rvIsaPkg::wordT memData,   // extended load value
    output rvIsaPkg::wordT regA,
    output rvIsaPkg::wordT regB
);
    import rvIsaPkg::*;
    import rvCtrlPkg::*;

    wordT regs [NUM_REGS]; // entry 0 stays zero
    wordT wbData;          // value headed for rd

    always_comb begin
        case (ctrl.wbSel)
            WB_MEM:  wbData = memData;
            WB_IMM:  wbData = dec.imm; // lui
            default: wbData = aluResult;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.regWrite && dec.rd != '0) begin // x0 writes dropped
            regs[dec.rd] <= wbData;
        end
    end

    // async reads, x0 forced
    assign regA = (dec.rs1 == '0) ? '0 : regs[dec.rs1];
    assign regB = (dec.rs2 == '0) ? '0 : regs[dec.rs2];

    x0StaysZero: assert property (@(posedge clk) disable iff (!arstN) regs[0] == '0)
        else $error("x0 holds %h", regs[0]);

    // illegal opcode leaves rd untouched across the edge
    illegalNoWrite: assert property (@(posedge clk) disable iff (!arstN)
        ctrl.illegal |=> regs[$past(dec.rd)] == $past(regs[dec.rd]))
        else $error("register changed on illegal instruction");

endmodule

`default_nettype wire

//--- hw/alu.sv
`default_nettype none

module alu (
    decodeIf.dst dec,                 // opcode, funct3/7, imm
    ctrlIf.dst   ctrl,                // aluSrc, isBranch
    input  rvIsaPkg::wordT regA,      // rs1 value
    input  rvIsaPkg::wordT regB,      // rs2 value
    output rvIsaPkg::wordT result,
    output logic           zeroFlag,  // result == 0
    output logic           branchTaken
);
    import rvIsaPkg::*;

    wordT       opB;   // second operand after mux
    aluOpT      aluOp;
    logic [4:0] shamt;
    logic       cond;  // compare outcome, branches only

    assign opB   = ctrl.aluSrc ? dec.imm : regB;
    assign shamt = opB[4:0]; // slli imm carries funct7 above

    // operation select
    always_comb begin
        aluOp = opAdd; // loads, stores, lui
        case (dec.opcode)
            OPC_OP,
            OPC_OPIMM: begin
                case (dec.funct3)
                    3'b000:  aluOp = (dec.opcode == OPC_OP && dec.funct7[5]) ? opSub : opAdd;
                    3'b001:  aluOp = opSll;
                    3'b010:  aluOp = opSlt;
                    3'b011:  aluOp = opSltu;
                    3'b100:  aluOp = opXor;
                    3'b101:  aluOp = dec.funct7[5] ? opSra : opSrl; // srai too
                    3'b110:  aluOp = opOr;
                    default: aluOp = opAnd;
                endcase
            end
            OPC_BRANCH: begin
                case (dec.funct3)
                    3'b000:  aluOp = opBeq;
                    3'b001:  aluOp = opBne;
                    3'b100:  aluOp = opBlt;
                    3'b101:  aluOp = opBge;
                    3'b110:  aluOp = opBltu;
                    3'b111:  aluOp = opBgeu;
                    default: aluOp = opSub; // illegal kind, never taken
                endcase
            end
            default: aluOp = opAdd;
        endcase
    end

    always_comb begin
        case (aluOp)
            opAdd:   result = regA + opB;
            opSll:   result = regA << shamt;
            opSlt:   result = {31'b0, $signed(regA) < $signed(opB)};
            opSltu:  result = {31'b0, regA < opB};
            opXor:   result = regA ^ opB;
            opSrl:   result = regA >> shamt;
            opSra:   result = $signed(regA) >>> shamt; // keeps sign
            opOr:    result = regA | opB;
            opAnd:   result = regA & opB;
            default: result = regA - opB; // sub and all compares
        endcase
    end

    always_comb begin
        case (aluOp)
            opBeq:   cond = (regA == opB);
            opBne:   cond = (regA != opB);
            opBlt:   cond = ($signed(regA) < $signed(opB));
            opBge:   cond = ($signed(regA) >= $signed(opB));
            opBltu:  cond = (regA < opB);
            opBgeu:  cond = (regA >= opB);
            default: cond = 1'b0;
        endcase
    end

    assign zeroFlag    = (result == '0);
    assign branchTaken = ctrl.isBranch && cond;

    // a true compare needs the control unit to have flagged a branch
    always_comb begin
        takenOnlyOnBranch: assert final (!cond || ctrl.isBranch)
            else $error("compare true without isBranch, opcode %b", dec.opcode);
    end

endmodule

`default_nettype wire

//--- hw/controlUnit.sv
`default_nettype none

module controlUnit (
    decodeIf.dst dec, // opcode, funct3
    ctrlIf.src   ctrl // control levels out
);
    import rvIsaPkg::*;
    import rvCtrlPkg::*;

    always_comb begin
        ctrl.wbSel    = WB_ALU; // defaults, nothing happens
        ctrl.aluSrc   = 1'b0;
        ctrl.regWrite = 1'b0;
        ctrl.isBranch = 1'b0;
        ctrl.memRead  = 1'b0;
        ctrl.memWrite = 1'b0;
        ctrl.illegal  = 1'b0;
        case (dec.opcode)
            OPC_OP: begin
                ctrl.regWrite = 1'b1; // rd = rs1 op rs2
            end
            OPC_OPIMM: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            OPC_LOAD: begin
                ctrl.aluSrc   = 1'b1; // rs1 + offset
                ctrl.memRead  = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.wbSel    = WB_MEM;
            end
            OPC_STORE: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            OPC_BRANCH: begin
                ctrl.isBranch = 1'b1;
                ctrl.illegal  = (dec.funct3 == 3'd2) || (dec.funct3 == 3'd3); // no such compare
            end
            OPC_LUI: begin
                ctrl.regWrite = 1'b1;
                ctrl.wbSel    = WB_IMM; // imm straight to rd
            end
            default: begin
                ctrl.illegal  = 1'b1; // jal, jalr, auipc, system...
            end
        endcase
        if (ctrl.illegal) begin // no side effects
            ctrl.regWrite = 1'b0;
            ctrl.memRead  = 1'b0;
            ctrl.memWrite = 1'b0;
        end
    end

    // the memory port never sees both strobes at once
    always_comb begin
        memExclusive: assert final (!(ctrl.memRead && ctrl.memWrite))
            else $error("memRead and memWrite both high, opcode %b", dec.opcode);
    end

endmodule

`default_nettype wire

//--- hw/instrDecoder.sv
`default_nettype none

module instrDecoder (
    input rvIsaPkg::wordT instr, // raw instruction word
    decodeIf.src dec             // fields and immediate out
);
    import rvIsaPkg::*;

    opcodeT opcode;
    wordT immI; // addi, loads
    wordT immS; // stores
    wordT immB; // branches
    wordT immU; // lui

    assign opcode     = instr[6:0];
    assign dec.opcode = opcode;
    assign dec.rd     = instr[11:7];
    assign dec.funct3 = instr[14:12];
    assign dec.rs1    = instr[19:15];
    assign dec.rs2    = instr[24:20];
    assign dec.funct7 = instr[31:25];

    // sign bit always sits at instr[31]
    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immU = {instr[31:12], 12'b0}; // upper 20, low zeroed

    always_comb begin
        case (opcode)
            OPC_OPIMM,
            OPC_LOAD:   dec.imm = immI;
            OPC_STORE:  dec.imm = immS;
            OPC_BRANCH: dec.imm = immB; // offset only, no pc here
            OPC_LUI:    dec.imm = immU;
            default:    dec.imm = '0;   // op and unknown formats
        endcase
    end

endmodule

`default_nettype wire

//--- hw/ctrlIf.sv
`default_nettype none

interface ctrlIf;
    import rvCtrlPkg::*;

    wbSelT wbSel;    // write-back source
    logic  aluSrc;   // operand b from imm
    logic  regWrite; // rd gets written at clk edge
    logic  isBranch;
    logic  memRead;
    logic  memWrite;
    logic  illegal;  // opcode not handled here

    modport src (output wbSel, aluSrc, regWrite, isBranch, memRead, memWrite, illegal);
    modport dst (input wbSel, aluSrc, regWrite, isBranch, memRead, memWrite, illegal);

endinterface

`default_nettype wire

//--- hw/decodeIf.sv
`default_nettype none

interface decodeIf;
    import rvIsaPkg::*;

    regAddrT rs1;    // source register 1
    regAddrT rs2;    // source register 2
    regAddrT rd;     // destination
    opcodeT  opcode;
    funct3T  funct3; // alu op, branch kind or access size
    funct7T  funct7; // bit 5 picks sub/sra
    wordT    imm;    // sign-extended immediate

    modport src (output rs1, rs2, rd, opcode, funct3, funct7, imm);
    modport dst (input rs1, rs2, rd, opcode, funct3, funct7, imm);

endinterface

`default_nettype wire

//--- hw/rvCtrlPkg.sv
`default_nettype none

package rvCtrlPkg;

    typedef logic [1:0] wbSelT;  // register write-back source
    typedef logic [3:0] byteEnT; // one bit per byte lane

    localparam wbSelT WB_ALU = 2'd0; // alu result
    localparam wbSelT WB_MEM = 2'd1; // extended load data
    localparam wbSelT WB_IMM = 2'd2; // immediate, lui

    // lane-0 based enable patterns, shifted up by address
    localparam byteEnT BE_NONE = 4'b0000;
    localparam byteEnT BE_BYTE = 4'b0001;
    localparam byteEnT BE_HALF = 4'b0011;
    localparam byteEnT BE_WORD = 4'b1111;

endpackage

`default_nettype wire

//--- hw/rvIsaPkg.sv
`default_nettype none

package rvIsaPkg;

    typedef logic [31:0] wordT;    // data word, register value
    typedef logic [4:0]  regAddrT; // register index
    typedef logic [6:0]  opcodeT;
    typedef logic [2:0]  funct3T;
    typedef logic [6:0]  funct7T;
    typedef logic [3:0]  aluOpT;   // internal alu operation

    localparam int NUM_REGS = 32;  // x0..x31

    // alu operations, branch compares share the same space
    localparam aluOpT opAdd  = 4'd0;
    localparam aluOpT opSub  = 4'd1;
    localparam aluOpT opSll  = 4'd2;
    localparam aluOpT opSlt  = 4'd3;
    localparam aluOpT opSltu = 4'd4;
    localparam aluOpT opXor  = 4'd5;
    localparam aluOpT opSrl  = 4'd6;
    localparam aluOpT opSra  = 4'd7;
    localparam aluOpT opOr   = 4'd8;
    localparam aluOpT opAnd  = 4'd9;
    localparam aluOpT opBeq  = 4'd10;
    localparam aluOpT opBne  = 4'd11;
    localparam aluOpT opBlt  = 4'd12;
    localparam aluOpT opBge  = 4'd13;
    localparam aluOpT opBltu = 4'd14;
    localparam aluOpT opBgeu = 4'd15;

    localparam opcodeT OPC_OP     = 7'b0110011; // reg-reg
    localparam opcodeT OPC_OPIMM  = 7'b0010011; // reg-imm
    localparam opcodeT OPC_LOAD   = 7'b0000011;
    localparam opcodeT OPC_STORE  = 7'b0100011;
    localparam opcodeT OPC_BRANCH = 7'b1100011;
    localparam opcodeT OPC_LUI    = 7'b0110111;

    localparam funct3T SZ_BYTE = 3'b000; // lb/lbu/sb
    localparam funct3T SZ_HALF = 3'b001; // lh/lhu/sh
    localparam funct3T SZ_WORD = 3'b010; // lw/sw
    localparam int SZ_UNSIGNED_BIT = 2;  // funct3 bit for lbu/lhu

endpackage

`default_nettype wire
